/* files.f */
hw/periph_pkg.sv
hw/rgb_pwm.sv
hw/tick_timer.sv
hw/periph_readback.sv
hw/periph_top.sv
sim/periph_assertions.sv
sim/periph_checker.sv
sim/tb_periph.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_periph
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Regression failed
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(BINARY) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_periph.sv */
`timescale 1ns/10ps

module tb_periph;

	localparam int len_reset = 8;
	localparam int len_idle = 40;
	localparam int len_duty = 100;
	localparam int len_packed = 100;
	localparam int len_oneshot = 40;
	localparam int len_auto = 3 * 24 + 20;
	localparam int len_unmapped = 24;
	localparam int cycle_limit = len_reset + len_idle + len_duty + len_packed
		+ len_oneshot + len_auto + len_unmapped + 100;  // plus margin

	logic        CLK = 1'b0;
	logic        RSTb = 1'b0;
	logic [7:0]  address = '0;
	logic [15:0] data_in = '0;
	logic        wr = 1'b0;
	logic        check_rd = 1'b0;
	logic [15:0] data_out;
	logic        red;
	logic        green;
	logic        blue;
	logic        irq;
	logic        led_active;

	logic [31:0] lfsr = 32'h6290_e3ad;
	int          cycles = 0;

	// mapped addresses walked after reset
	logic [7:0] periph_pkg_addrs [8] = '{
		periph_pkg::addr_red, periph_pkg::addr_green, periph_pkg::addr_blue,
		periph_pkg::addr_rgb_packed, periph_pkg::addr_tmr_reload,
		periph_pkg::addr_tmr_ctrl, periph_pkg::addr_tmr_count,
		periph_pkg::addr_tmr_status
	};

	periph_top dut_i (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.address    (address),
		.data_in    (data_in),
		.wr         (wr),
		.data_out   (data_out),
		.red        (red),
		.green      (green),
		.blue       (blue),
		.irq        (irq),
		.led_active (led_active)
	);

	periph_checker chk_i (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.address    (address),
		.data_in    (data_in),
		.wr         (wr),
		.check_rd   (check_rd),
		.data_out   (data_out),
		.red        (red),
		.green      (green),
		.blue       (blue),
		.led_active (led_active)
	);

	bind periph_top periph_assertions assertions_i (
		.CLK        (CLK),
		.RSTb       (RSTb),
		.red        (red),
		.green      (green),
		.blue       (blue),
		.red_duty   (rgb_pwm_i.red_duty),
		.green_duty (rgb_pwm_i.green_duty),
		.blue_duty  (rgb_pwm_i.blue_duty),
		.expired    (expired),
		.enable     (tick_timer_i.enable),
		.irq        (irq)
	);

	initial begin
		forever begin
			#4 CLK = ~CLK;
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);  // one step per bit
			v = {v[14:0], lfsr[0]};
		end
	endtask

	task automatic write_reg(input logic [7:0] a, input logic [15:0] d);
		@(negedge CLK);
		address = a;
		data_in = d;
		wr = 1'b1;
		@(negedge CLK);
		wr = 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] a, input logic chk, output logic [15:0] v);
		@(negedge CLK);
		address = a;
		check_rd = chk;
		@(negedge CLK);
		v = data_out;  // registered one cycle later
		check_rd = 1'b0;
	endtask

	task automatic wait_expiry(input logic [15:0] rl, input int limit, output logic seen);
		logic [15:0] v;
		logic [15:0] prev;
		logic        prev_ok;
		seen = 1'b0;
		prev = '0;
		prev_ok = 1'b0;
		@(negedge CLK);
		address = periph_pkg::addr_tmr_count;
		for (int i = 0; i < limit && !seen; i++) begin
			@(negedge CLK);
			v = data_out;
			if (irq) begin
				seen = 1'b1;
			end else begin
				if (v > rl) chk_i.report_failure("count above reload");
				if (prev_ok && prev != 16'd0 && v >= prev) begin
					chk_i.report_failure("count did not decrease");
				end
				prev = v;
				prev_ok = 1'b1;
			end
		end
	endtask

	initial begin
		logic [15:0] v;
		logic [15:0] rl;
		logic        seen;

		repeat (4) @(posedge CLK);
		@(negedge CLK);
		RSTb = 1'b1;

		chk_i.start_test("reset state");
		foreach (periph_pkg_addrs[i]) begin
			read_reg(periph_pkg_addrs[i], 1'b0, v);
			chk_i.compare_value($sformatf("reset read %02h", periph_pkg_addrs[i]), 16'd0, v);
		end
		repeat (16) begin
			@(negedge CLK);
			chk_i.compare_value("outputs", 16'd0, {11'd0, red, green, blue, irq, led_active});
		end
		chk_i.end_test();

		chk_i.start_test("duty registers");
		rand_bits(16, v);
		write_reg(periph_pkg::addr_red, v);
		rand_bits(16, v);
		write_reg(periph_pkg::addr_green, v);
		rand_bits(16, v);
		write_reg(periph_pkg::addr_blue, v);
		read_reg(periph_pkg::addr_red, 1'b1, v);
		read_reg(periph_pkg::addr_green, 1'b1, v);
		read_reg(periph_pkg::addr_blue, 1'b1, v);
		repeat (2) @(negedge CLK);
		chk_i.measure_pwm();
		chk_i.end_test();

		chk_i.start_test("packed colors");
		rand_bits(16, v);
		write_reg(periph_pkg::addr_rgb_packed, v);
		read_reg(periph_pkg::addr_red, 1'b1, v);
		read_reg(periph_pkg::addr_green, 1'b1, v);
		read_reg(periph_pkg::addr_blue, 1'b1, v);
		repeat (2) @(negedge CLK);
		chk_i.measure_pwm();
		chk_i.end_test();

		chk_i.start_test("one shot timer");
		rand_bits(3, v);
		rl = v + 16'd3;
		write_reg(periph_pkg::addr_tmr_reload, rl);
		read_reg(periph_pkg::addr_tmr_reload, 1'b1, v);
		write_reg(periph_pkg::addr_tmr_ctrl, 16'h0001);
		seen = 1'b0;
		for (int i = 0; i < int'(rl) + 2 && !seen; i++) begin
			@(negedge CLK);
			seen = irq;
		end
		if (!seen) chk_i.report_failure("irq did not rise within reload + 2 cycles");
		read_reg(periph_pkg::addr_tmr_status, 1'b0, v);
		chk_i.compare_value("status", 16'h0001, v);
		read_reg(periph_pkg::addr_tmr_ctrl, 1'b0, v);
		chk_i.compare_value("ctrl enable", 16'h0000, v & 16'h0001);
		write_reg(periph_pkg::addr_tmr_status, 16'h0001);
		@(negedge CLK);
		chk_i.compare_value("irq after clear", 16'd0, {15'd0, irq});
		chk_i.end_test();

		chk_i.start_test("auto reload timer");
		rand_bits(3, v);
		rl = v + 16'd6;  // period long enough to watch the count between clears
		write_reg(periph_pkg::addr_tmr_reload, rl);
		write_reg(periph_pkg::addr_tmr_ctrl, 16'h0003);
		for (int n = 0; n < 3; n++) begin
			wait_expiry(rl, int'(rl) + 6, seen);
			if (!seen) chk_i.report_failure("expired did not rise again");
			write_reg(periph_pkg::addr_tmr_status, 16'h0001);
			@(negedge CLK);
			chk_i.compare_value("irq after clear", 16'd0, {15'd0, irq});
		end
		write_reg(periph_pkg::addr_tmr_ctrl, 16'h0000);
		chk_i.end_test();

		chk_i.start_test("unmapped address");
		read_reg(8'h2a, 1'b1, v);
		rand_bits(16, v);
		write_reg(8'h2a, v);
		read_reg(8'h2a, 1'b1, v);
		read_reg(periph_pkg::addr_red, 1'b1, v);
		read_reg(periph_pkg::addr_green, 1'b1, v);
		read_reg(periph_pkg::addr_blue, 1'b1, v);
		read_reg(periph_pkg::addr_tmr_reload, 1'b1, v);
		chk_i.end_test();

		chk_i.print_summary();
		if (chk_i.error_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* sim/periph_checker.sv */
`timescale 1ns/10ps

module periph_checker (
	input logic        CLK,
	input logic        RSTb,
	input logic [7:0]  address,
	input logic [15:0] data_in,
	input logic        wr,
	input logic        check_rd,
	input logic [15:0] data_out,
	input logic        red,
	input logic        green,
	input logic        blue,
	input logic        led_active
);

	string       cur_name = "none";
	int          test_count = 0;
	int          failed_count = 0;
	int          error_count = 0;
	int          test_errors = 0;

	logic [5:0]  red_duty = '0;   // shadow registers from observed writes
	logic [5:0]  green_duty = '0;
	logic [5:0]  blue_duty = '0;
	logic [15:0] reload = '0;

	logic        rd_pending = 1'b0;
	logic [15:0] rd_expected = '0;
	logic [7:0]  rd_address = '0;

	// expected readback of the modeled registers
	function automatic logic [15:0] expected_read(input logic [7:0] a);
		case (a)
			periph_pkg::addr_red:        return {10'd0, red_duty};
			periph_pkg::addr_green:      return {10'd0, green_duty};
			periph_pkg::addr_blue:       return {10'd0, blue_duty};
			periph_pkg::addr_tmr_reload: return reload;
			default:                     return 16'd0;  // unmapped
		endcase
	endfunction

	task automatic start_test(input string name);
		cur_name = name;
		test_errors = 0;
	endtask

	task automatic compare_value(input string what, input logic [15:0] exp,
		input logic [15:0] act);
		if (exp !== act) begin
			$display("Error %s, %s: expected %0h, actual %0h", cur_name, what, exp, act);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("test %s: %s", cur_name, msg);
		error_count++;
		test_errors++;
	endtask

	task automatic end_test();
		test_count++;
		if (test_errors == 0) begin
			$display("test %s: ok", cur_name);
		end else begin
			failed_count++;
			$display("test %s: failed with %0d errors", cur_name, test_errors);
		end
	endtask

	task automatic print_summary();
		$display("tests %0d, failed %0d, errors %0d", test_count, failed_count, error_count);
	endtask

	// counts high cycles over one full pwm period
	task automatic measure_pwm();
		int   r;
		int   g;
		int   b;
		logic prev_any;
		r = 0;
		g = 0;
		b = 0;
		@(negedge CLK);
		prev_any = red | green | blue;
		repeat (64) begin
			@(negedge CLK);
			if (led_active !== prev_any) begin
				report_failure("led_active does not follow the color levels");
			end
			if (red) r++;
			if (green) g++;
			if (blue) b++;
			prev_any = red | green | blue;
		end
		compare_value("red high count", {10'd0, red_duty}, 16'(r));
		compare_value("green high count", {10'd0, green_duty}, 16'(g));
		compare_value("blue high count", {10'd0, blue_duty}, 16'(b));
	endtask

	always @(posedge CLK) begin
		periph_pkg::color_word_u word;
		rd_pending = check_rd;
		rd_expected = expected_read(address);  // state before this edge
		rd_address = address;
		word.raw = data_in;
		if (!RSTb) begin
			red_duty = '0;
			green_duty = '0;
			blue_duty = '0;
			reload = '0;
		end else if (wr) begin
			case (address)
				periph_pkg::addr_red:        red_duty = data_in[5:0];
				periph_pkg::addr_green:      green_duty = data_in[5:0];
				periph_pkg::addr_blue:       blue_duty = data_in[5:0];
				periph_pkg::addr_rgb_packed: begin
					red_duty = {word.field.red, 1'b0};
					green_duty = {word.field.green, 1'b0};
					blue_duty = {word.field.blue, 1'b0};
				end
				periph_pkg::addr_tmr_reload: reload = data_in;
				default: ;
			endcase
		end
	end

	always @(negedge CLK) begin
		if (rd_pending) begin
			compare_value($sformatf("read of %02h", rd_address), rd_expected, data_out);
		end
	end

endmodule

/* sim/periph_assertions.sv */
`timescale 1ns/10ps

module periph_assertions (
	input logic       CLK,
	input logic       RSTb,
	input logic       red,
	input logic       green,
	input logic       blue,
	input logic [5:0] red_duty,
	input logic [5:0] green_duty,
	input logic [5:0] blue_duty,
	input logic       expired,
	input logic       enable,
	input logic       irq
);

	red_low: assert property (@(posedge CLK) (!RSTb || red_duty == 6'd0) |=> !red)
		else $error("red output high while in reset or with zero duty");

	green_low: assert property (@(posedge CLK) (!RSTb || green_duty == 6'd0) |=> !green)
		else $error("green output high while in reset or with zero duty");

	blue_low: assert property (@(posedge CLK) (!RSTb || blue_duty == 6'd0) |=> !blue)
		else $error("blue output high while in reset or with zero duty");

	irq_follow: assert property (@(posedge CLK) RSTb |=> (irq == $past(expired)))
		else $error("irq did not follow expired by one cycle");

	no_idle_expiry: assert property (@(posedge CLK) !enable |=> !$rose(expired))
		else $error("expired rose while the timer was disabled");

endmodule

/* hw/periph_top.sv */
`timescale 1ns/10ps

module periph_top #(
	parameter int BITS         = periph_pkg::data_bits,
	parameter int ADDRESS_BITS = periph_pkg::addr_bits
) (
	input  logic                    CLK,
	input  logic                    RSTb,
	input  logic [ADDRESS_BITS-1:0] address,
	input  logic [BITS-1:0]         data_in,
	input  logic                    wr,
	output logic [BITS-1:0]         data_out,
	output logic                    red,
	output logic                    green,
	output logic                    blue,
	output logic                    irq,
	output logic                    led_active
);

	logic            pwm_wr;
	logic            tmr_wr;
	logic [BITS-1:0] pwm_rd_data;
	logic [BITS-1:0] tmr_rd_data;
	logic            expired;

	rgb_pwm #(
		.BITS         (BITS),
		.ADDRESS_BITS (ADDRESS_BITS)
	) rgb_pwm_i (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.address (address),
		.data_in (data_in),
		.wr      (pwm_wr),
		.rd_data (pwm_rd_data),
		.red     (red),
		.green   (green),
		.blue    (blue)
	);

	tick_timer #(
		.BITS         (BITS),
		.ADDRESS_BITS (ADDRESS_BITS)
	) tick_timer_i (
		.CLK     (CLK),
		.RSTb    (RSTb),
		.address (address),
		.data_in (data_in),
		.wr      (tmr_wr),
		.rd_data (tmr_rd_data),
		.expired (expired)
	);

	periph_readback #(
		.BITS         (BITS),
		.ADDRESS_BITS (ADDRESS_BITS)
	) periph_readback_i (
		.CLK         (CLK),
		.RSTb        (RSTb),
		.address     (address),
		.wr          (wr),
		.pwm_rd_data (pwm_rd_data),
		.tmr_rd_data (tmr_rd_data),
		.expired     (expired),
		.red         (red),
		.green       (green),
		.blue        (blue),
		.pwm_wr      (pwm_wr),
		.tmr_wr      (tmr_wr),
		.data_out    (data_out),
		.irq         (irq),
		.led_active  (led_active)
	);

endmodule

/* hw/periph_readback.sv */
`timescale 1ns/10ps

module periph_readback #(
	parameter int BITS         = 16,
	parameter int ADDRESS_BITS = 8
) (
	input  logic                    CLK,
	input  logic                    RSTb,
	input  logic [ADDRESS_BITS-1:0] address,
	input  logic                    wr,
	input  logic [BITS-1:0]         pwm_rd_data,
	input  logic [BITS-1:0]         tmr_rd_data,
	input  logic                    expired,
	input  logic                    red,
	input  logic                    green,
	input  logic                    blue,
	output logic                    pwm_wr,
	output logic                    tmr_wr,
	output logic [BITS-1:0]         data_out,
	output logic                    irq,
	output logic                    led_active
);

	localparam int rw = ADDRESS_BITS - 4;

	logic [rw-1:0] region;
	logic          sel_pwm;
	logic          sel_tmr;

	assign region  = address[ADDRESS_BITS-1:4];  // upper nibble picks the block
	assign sel_pwm = (region == rw'(periph_pkg::region_pwm));
	assign sel_tmr = (region == rw'(periph_pkg::region_tmr));

	assign pwm_wr = wr && sel_pwm;
	assign tmr_wr = wr && sel_tmr;

	always_ff @(posedge CLK) begin
		if (sel_pwm) begin
			data_out <= pwm_rd_data;
		end else if (sel_tmr) begin
			data_out <= tmr_rd_data;
		end else begin
			data_out <= '0;  // unmapped region
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			irq        <= 1'b0;
			led_active <= 1'b0;
		end else begin
			irq        <= expired;
			led_active <= red | green | blue;
		end
	end

endmodule

/* hw/tick_timer.sv */
`timescale 1ns/10ps

module tick_timer #(
	parameter int BITS         = 16,
	parameter int ADDRESS_BITS = 8
) (
	input  logic                    CLK,
	input  logic                    RSTb,
	input  logic [ADDRESS_BITS-1:0] address,
	input  logic [BITS-1:0]         data_in,
	input  logic                    wr,
	output logic [BITS-1:0]         rd_data,
	output logic                    expired
);

	localparam logic [ADDRESS_BITS-1:0] a_reload = ADDRESS_BITS'(periph_pkg::addr_tmr_reload);
	localparam logic [ADDRESS_BITS-1:0] a_ctrl   = ADDRESS_BITS'(periph_pkg::addr_tmr_ctrl);
	localparam logic [ADDRESS_BITS-1:0] a_count  = ADDRESS_BITS'(periph_pkg::addr_tmr_count);
	localparam logic [ADDRESS_BITS-1:0] a_status = ADDRESS_BITS'(periph_pkg::addr_tmr_status);

	logic [BITS-1:0] reload;
	logic [BITS-1:0] count;
	logic            enable;
	logic            auto_reload;

	logic [BITS-1:0] reload_next;
	logic [BITS-1:0] count_next;
	logic            enable_next;
	logic            auto_reload_next;
	logic            expired_next;

	logic wr_reload;
	logic wr_ctrl;
	logic wr_status;
	logic hit_zero;

	assign wr_reload = wr && (address == a_reload);
	assign wr_ctrl   = wr && (address == a_ctrl);
	assign wr_status = wr && (address == a_status);
	assign hit_zero  = enable && (count == '0);

	always_comb begin
		reload_next      = reload;
		count_next       = count;
		enable_next      = enable;
		auto_reload_next = auto_reload;
		expired_next     = expired;

		if (wr_reload) begin
			reload_next = data_in;
		end

		if (wr_status && data_in[0]) begin
			expired_next = 1'b0;
		end

		if (hit_zero) begin
			expired_next = 1'b1;  // new expiry beats the clear
			if (auto_reload) begin
				count_next = reload;
			end else begin
				enable_next = 1'b0;
			end
		end else if (enable) begin
			count_next = count - 1'b1;
		end

		// ctrl write overrides the tick
		if (wr_ctrl) begin
			enable_next      = data_in[0];
			auto_reload_next = data_in[1];
			if (data_in[0]) begin
				count_next = reload;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			reload      <= '0;
			count       <= '0;
			enable      <= 1'b0;
			auto_reload <= 1'b0;
			expired     <= 1'b0;
		end else begin
			reload      <= reload_next;
			count       <= count_next;
			enable      <= enable_next;
			auto_reload <= auto_reload_next;
			expired     <= expired_next;
		end
	end

	always_comb begin
		case (address)
			a_reload: rd_data = reload;
			a_ctrl:   rd_data = BITS'({auto_reload, enable});
			a_count:  rd_data = count;
			a_status: rd_data = BITS'(expired);
			default:  rd_data = '0;
		endcase
	end

endmodule

/* hw/rgb_pwm.sv */
`timescale 1ns/10ps

module rgb_pwm #(
	parameter int BITS         = 16,
	parameter int ADDRESS_BITS = 8
) (
	input  logic                    CLK,
	input  logic                    RSTb,
	input  logic [ADDRESS_BITS-1:0] address,
	input  logic [BITS-1:0]         data_in,
	input  logic                    wr,
	output logic [BITS-1:0]         rd_data,
	output logic                    red,
	output logic                    green,
	output logic                    blue
);

	localparam int pw = periph_pkg::pwm_bits;

	localparam logic [ADDRESS_BITS-1:0] a_red    = ADDRESS_BITS'(periph_pkg::addr_red);
	localparam logic [ADDRESS_BITS-1:0] a_green  = ADDRESS_BITS'(periph_pkg::addr_green);
	localparam logic [ADDRESS_BITS-1:0] a_blue   = ADDRESS_BITS'(periph_pkg::addr_blue);
	localparam logic [ADDRESS_BITS-1:0] a_packed = ADDRESS_BITS'(periph_pkg::addr_rgb_packed);

	logic [pw-1:0] red_duty;
	logic [pw-1:0] green_duty;
	logic [pw-1:0] blue_duty;

	logic [pw-1:0] red_duty_next;
	logic [pw-1:0] green_duty_next;
	logic [pw-1:0] blue_duty_next;

	logic [pw-1:0] pwm_ctr = '0;

	periph_pkg::color_word_u wr_word;
	periph_pkg::color_word_u rd_word;

	// register write decode
	always_comb begin
		wr_word.raw     = 16'(data_in);
		red_duty_next   = red_duty;
		green_duty_next = green_duty;
		blue_duty_next  = blue_duty;

		if (wr) begin
			case (address)
				a_red: begin
					red_duty_next = wr_word.raw[pw-1:0];
				end
				a_green: begin
					green_duty_next = wr_word.raw[pw-1:0];
				end
				a_blue: begin
					blue_duty_next = wr_word.raw[pw-1:0];
				end
				a_packed: begin
					// 5 bit fields, low duty bit forced to zero
					red_duty_next   = pw'({wr_word.field.red, 1'b0});
					green_duty_next = pw'({wr_word.field.green, 1'b0});
					blue_duty_next  = pw'({wr_word.field.blue, 1'b0});
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			red_duty   <= '0;
			green_duty <= '0;
			blue_duty  <= '0;
		end else begin
			red_duty   <= red_duty_next;
			green_duty <= green_duty_next;
			blue_duty  <= blue_duty_next;
		end
	end

	always_ff @(posedge CLK) begin
		pwm_ctr <= pwm_ctr + 1'b1;  // wraps every 2**pw cycles
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			red   <= 1'b0;
			green <= 1'b0;
			blue  <= 1'b0;
		end else begin
			red   <= (pwm_ctr < red_duty);
			green <= (pwm_ctr < green_duty);
			blue  <= (pwm_ctr < blue_duty);
		end
	end

	// readback, packed view drops the duty lsb
	always_comb begin
		rd_word.field.red   = 5'(red_duty >> 1);
		rd_word.field.green = 5'(green_duty >> 1);
		rd_word.field.blue  = 5'(blue_duty >> 1);
		rd_word.field.spare = 1'b0;

		case (address)
			a_red:    rd_data = BITS'(red_duty);
			a_green:  rd_data = BITS'(green_duty);
			a_blue:   rd_data = BITS'(blue_duty);
			a_packed: rd_data = BITS'(rd_word.raw);
			default:  rd_data = '0;
		endcase
	end

endmodule

/* hw/periph_pkg.sv */
package periph_pkg;

	localparam int data_bits = 16;
	localparam int addr_bits = 8;
	localparam int pwm_bits  = 6;  // 64 cycle period

	// rgb block
	localparam logic [7:0] addr_red        = 8'h00;
	localparam logic [7:0] addr_green      = 8'h01;
	localparam logic [7:0] addr_blue       = 8'h02;
	localparam logic [7:0] addr_rgb_packed = 8'h03;

	// timer block
	localparam logic [7:0] addr_tmr_reload = 8'h10;
	localparam logic [7:0] addr_tmr_ctrl   = 8'h11;  // bit0 enable, bit1 auto reload
	localparam logic [7:0] addr_tmr_count  = 8'h12;
	localparam logic [7:0] addr_tmr_status = 8'h13;  // bit0 expired, write 1 clears

	localparam logic [3:0] region_pwm = 4'h0;
	localparam logic [3:0] region_tmr = 4'h1;

	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [4:0] red;    // bits 15:11
			logic [4:0] green;  // bits 10:6
			logic [4:0] blue;   // bits 5:1
			logic       spare;
		} field;
	} color_word_u;

endpackage
